// File: testbench/joiner_testdata.txt
// mask _ len0 _ len1 _ len2 _ len3 _ out_tready duty (0-f) _ abort after beats _ expect error
// One operation per line, lengths of unselected channels are ignored
f_3_1_4_2_f_00_0
f_1_5_2_3_8_00_0
a_0_4_0_2_f_00_0
5_3_0_2_0_6_00_0
0_0_0_0_0_f_00_1
8_0_0_0_6_5_00_0
f_4_4_4_4_c_05_0
3_2_3_0_0_f_00_0
0_0_0_0_0_f_00_1
6_0_7_1_0_3_00_0
9_2_0_0_3_f_02_0
c_0_0_5_5_7_00_0

// File: sim.f
hdl/join_cfg_pkg.sv
hdl/join_ctrl_pkg.sv
hdl/stream_if.sv
hdl/channel_arbiter.sv
hdl/stream_select_mux.sv
hdl/packet_joiner.sv
hdl/joiner_top.sv
testbench/joiner_checker.sv
testbench/joiner_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the joiner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module joiner_tb -o joiner_sim

status=0
./obj_dir/joiner_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
  exit 1
fi

// File: testbench/joiner_tb.sv
`timescale 1ns/1ps
`default_nettype none

module joiner_tb import join_cfg_pkg::*, join_ctrl_pkg::*; ();

  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int max_ops      = 32;
  localparam int max_len      = 16;

  logic                               clk;
  logic                               int_rst;
  logic                               abort;
  logic                               start;
  logic [num_channels-1:0]            use_mask;
  logic                               busy;
  logic                               complete;
  logic                               error;
  logic                               beat_sent;
  logic [num_channels*data_width-1:0] in_tdata;
  logic [num_channels*keep_width-1:0] in_tkeep;
  logic [num_channels-1:0]            in_tvalid;
  logic [num_channels-1:0]            in_tready;
  logic [num_channels-1:0]            in_tlast;
  logic [data_width-1:0]              out_tdata;
  logic [keep_width-1:0]              out_tkeep;
  logic                               out_tvalid;
  logic                               out_tready;
  logic                               out_tlast;
  int                                 value_errors;
  int                                 status_errors;
  int                                 other_errors = 0;
  int                                 watchdog_ns = 0;

  // Operation word with the fields of one data file line
  logic [35:0]           ops [max_ops];
  logic [data_width-1:0] pkt_data [num_channels][max_len];
  logic [keep_width-1:0] pkt_keep [num_channels][max_len];

  joiner_top dut0 (.*);

  joiner_checker chk0 (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before all operations finished", watchdog_ns);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [num_channels-1:0] mask;
    int len [num_channels];
    int sent [num_channels];
    int n_ops;
    int total_beats;
    int duty;
    int abort_after;
    int out_count;
    int top_ch;
    bit exp_err;
    bit aborting;
    bit over;

    int_rst    = 1'b1;
    abort      = 1'b0;
    start      = 1'b0;
    use_mask   = '0;
    in_tdata   = '0;
    in_tkeep   = '0;
    in_tvalid  = '0;
    in_tlast   = '0;
    out_tready = 1'b0;
    void'($urandom(32'h8a61_6f5f));

    for (int i = 0; i < max_ops; i++) begin
      ops[i] = '0;
    end
    $readmemh("testbench/joiner_testdata.txt", ops);
    // All-zero word ends the list
    n_ops = 0;
    total_beats = 0;
    while (n_ops < max_ops && ops[n_ops] != '0) begin
      for (int ch = 0; ch < num_channels; ch++) begin
        if (ops[n_ops][32 + ch]) begin
          total_beats += int'(ops[n_ops][31 - 4*ch -: 4]);
        end
      end
      n_ops++;
    end
    watchdog_ns = total_beats * 8 * clk_period + 2000;

    repeat (reset_cycles) @(posedge clk);
    int_rst <= 1'b0;
    repeat (2) @(posedge clk);

    for (int op = 0; op < n_ops; op++) begin
      mask        = ops[op][35:32];
      duty        = int'(ops[op][15:12]);
      abort_after = int'(ops[op][11:4]);
      exp_err     = ops[op][0];
      top_ch      = -1;
      for (int ch = 0; ch < num_channels; ch++) begin
        len[ch]  = mask[ch] ? int'(ops[op][31 - 4*ch -: 4]) : 0;
        sent[ch] = 0;
        if (mask[ch]) begin
          top_ch = ch;
        end
      end
      // Expected output, packets in ascending channel order
      for (int ch = 0; ch < num_channels; ch++) begin
        for (int b = 0; b < len[ch]; b++) begin
          pkt_data[ch][b] = $urandom;
          pkt_keep[ch][b] = keep_width'($urandom_range((1 << keep_width) - 1, 1));
          chk0.expect_beat(pkt_data[ch][b], pkt_keep[ch][b], ch == top_ch && b == len[ch] - 1);
        end
      end

      @(posedge clk);
      start     <= 1'b1;
      use_mask  <= mask;
      out_count = 0;
      aborting  = 1'b0;
      over      = 1'b0;
      while (!over) begin
        // Unsent beat is held until it transfers
        for (int ch = 0; ch < num_channels; ch++) begin
          in_tvalid[ch] <= (sent[ch] < len[ch]);
          if (sent[ch] < len[ch]) begin
            in_tdata[ch*data_width +: data_width] <= pkt_data[ch][sent[ch]];
            in_tkeep[ch*keep_width +: keep_width] <= pkt_keep[ch][sent[ch]];
            in_tlast[ch] <= (sent[ch] == len[ch] - 1);
          end
        end
        out_tready <= ($urandom_range(15, 0) <= duty);
        @(posedge clk);
        start <= 1'b0;
        if (aborting) begin
          abort <= 1'b0;
          over = 1'b1;
        end else if (complete || (exp_err && error)) begin
          over = 1'b1;
        end else if (out_tvalid && out_tready) begin
          out_count++;
        end
        for (int ch = 0; ch < num_channels; ch++) begin
          if (in_tvalid[ch] && in_tready[ch]) begin
            sent[ch]++;
          end
        end
        if (!over && abort_after != 0 && out_count >= abort_after) begin
          abort <= 1'b1;
          aborting = 1'b1;
        end
      end
      in_tvalid <= '0;
      in_tlast  <= '0;
      repeat (3) @(posedge clk);
    end

    repeat (4) @(posedge clk);
    if (chk0.pending_count() != 0) begin
      $display("%0d expected output beats never appeared", chk0.pending_count());
      other_errors++;
    end
    $display("Error counts: value %0d, status %0d, other %0d",
             value_errors, status_errors, other_errors);
    if (value_errors + status_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/joiner_checker.sv
`timescale 1ns/1ps
`default_nettype none

module joiner_checker import join_cfg_pkg::*; (
  input  logic                    clk,
  input  logic                    int_rst,
  input  logic                    abort,
  input  logic                    start,
  input  logic [num_channels-1:0] use_mask,
  input  logic                    busy,
  input  logic                    complete,
  input  logic                    error,
  input  logic                    beat_sent,
  input  logic [num_channels-1:0] in_tready,
  input  logic [data_width-1:0]   out_tdata,
  input  logic [keep_width-1:0]   out_tkeep,
  input  logic                    out_tvalid,
  input  logic                    out_tready,
  input  logic                    out_tlast,
  output int                      value_errors,
  output int                      status_errors
);

  // Expected beat packed as data, keep, last
  logic [data_width+keep_width:0] exp_q [$];
  logic [data_width+keep_width:0] head;
  logic [num_channels-1:0]        mask_m;
  logic                           busy_m;
  logic                           complete_m;
  logic                           error_m;
  logic                           beat_m;
  logic                           out_fire;
  logic                           last_fire;
  logic                           can_start;
  int                             value_count = 0;
  int                             status_count = 0;

  assign value_errors  = value_count;
  assign status_errors = status_count;
  assign out_fire      = out_tvalid && out_tready;
  assign last_fire     = out_fire && out_tlast;
  // Start is only taken in idle or done
  assign can_start     = !busy_m && !error_m;

  function automatic void expect_beat(
    input logic [data_width-1:0] d,
    input logic [keep_width-1:0] k,
    input logic                  l
  );
    exp_q.push_back({d, k, l});
  endfunction

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  function automatic void check_status(input string name, input logic expected,
                                       input logic actual);
    if (actual !== expected) begin
      $display("error: time %0t, %s expected %0b actual %0b", $time, name, expected, actual);
      status_count++;
    end
  endfunction

  function automatic void check_value(input string name, input logic [data_width-1:0] expected,
                                      input logic [data_width-1:0] actual);
    if (actual !== expected) begin
      $display("error: time %0t, %s expected %h actual %h", $time, name, expected, actual);
      value_count++;
    end
  endfunction

  always @(posedge clk) begin
    if (int_rst) begin
      busy_m     <= 1'b0;
      complete_m <= 1'b0;
      error_m    <= 1'b0;
      beat_m     <= 1'b0;
      mask_m     <= '0;
    end else begin
      check_status("busy", busy_m, busy);
      check_status("complete", complete_m, complete);
      check_status("error", error_m, error);
      check_status("beat_sent", beat_m, beat_sent);
      // Ready only toward a channel of the running operation
      if ((in_tready & ~(busy_m ? mask_m : '0)) != '0) begin
        $display("error: time %0t, in_tready expected %b actual %b",
                 $time, in_tready & (busy_m ? mask_m : '0), in_tready);
        status_count++;
      end
      if (abort) begin
        exp_q.delete();
      end else if (out_fire && exp_q.size() == 0) begin
        $display("Output beat at time %0t arrived when no beat was expected", $time);
        value_count++;
      end else if (out_fire) begin
        head = exp_q.pop_front();
        check_value("out_tdata", head[keep_width+1 +: data_width], out_tdata);
        check_value("out_tkeep", data_width'(head[1 +: keep_width]), data_width'(out_tkeep));
        check_value("out_tlast", data_width'(head[0]), data_width'(out_tlast));
      end
      busy_m     <= !abort && (busy_m ? !last_fire : (can_start && start && use_mask != '0));
      complete_m <= !abort && busy_m && last_fire;
      error_m    <= !abort && can_start && start && (use_mask == '0);
      beat_m     <= out_fire;
      if (can_start && start) begin
        mask_m <= use_mask;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/joiner_top.sv
`timescale 1ns/1ps
`default_nettype none

module joiner_top import join_cfg_pkg::*; (
  input  logic                               clk,
  input  logic                               int_rst,
  input  logic                               abort,
  input  logic                               start,
  input  logic [num_channels-1:0]            use_mask,
  output logic                               busy,
  output logic                               complete,
  output logic                               error,
  output logic                               beat_sent,

  input  logic [num_channels*data_width-1:0] in_tdata,
  input  logic [num_channels*keep_width-1:0] in_tkeep,
  input  logic [num_channels-1:0]            in_tvalid,
  output logic [num_channels-1:0]            in_tready,
  input  logic [num_channels-1:0]            in_tlast,

  output logic [data_width-1:0]              out_tdata,
  output logic [keep_width-1:0]              out_tkeep,
  output logic                               out_tvalid,
  input  logic                               out_tready,
  output logic                               out_tlast
);

  stream_if in_s [num_channels] ();
  stream_if out_s ();

  // Unpack per-channel vectors onto the input streams
  for (genvar g = 0; g < num_channels; g++) begin : g_map
    assign in_s[g].tdata     = in_tdata[g*data_width +: data_width];
    assign in_s[g].tkeep     = in_tkeep[g*keep_width +: keep_width];
    assign in_s[g].tvalid    = in_tvalid[g];
    assign in_s[g].tlast     = in_tlast[g];
    assign in_s[g].final_tag = 1'b0;
    assign in_tready[g]      = in_s[g].tready;
  end

  assign out_tdata    = out_s.tdata;
  assign out_tkeep    = out_s.tkeep;
  assign out_tvalid   = out_s.tvalid;
  assign out_tlast    = out_s.tlast;
  assign out_s.tready = out_tready;

  packet_joiner u_joiner (
    .clk       (clk),
    .int_rst   (int_rst),
    .abort     (abort),
    .start     (start),
    .use_mask  (use_mask),
    .busy      (busy),
    .complete  (complete),
    .error     (error),
    .beat_sent (beat_sent),
    .ins       (in_s),
    .out       (out_s)
  );

endmodule

`default_nettype wire

// File: hdl/packet_joiner.sv
`timescale 1ns/1ps
`default_nettype none

module packet_joiner import join_cfg_pkg::*; import join_ctrl_pkg::*; (
  input  logic                    clk,
  input  logic                    int_rst,
  input  logic                    abort,
  input  logic                    start,
  input  logic [num_channels-1:0] use_mask,
  output logic                    busy,
  output logic                    complete,
  output logic                    error,
  output logic                    beat_sent,
  stream_if.sink                  ins [num_channels],
  stream_if.source                out
);

  arb_if    arb ();
  stream_if mux_out ();

  op_state_t               state;
  logic [num_channels-1:0] remaining;
  logic [num_channels-1:0] ack;
  logic                    final_flag;
  logic                    mux_enable;
  logic                    mux_rst;
  logic                    out_fire;
  logic                    last_fire;

  // Last beat of the granted channel taken by the mux
  for (genvar g = 0; g < num_channels; g++) begin : g_ack
    assign ack[g] = arb.grant[g] && ins[g].tvalid && ins[g].tready && ins[g].tlast;
  end

  assign arb.request     = remaining;
  assign arb.acknowledge = ack;

  // Nothing left once the current channel finishes
  assign final_flag = (remaining & ~ack) == '0;

  assign mux_enable = arb.grant_valid && (state == op_run) && !abort;
  assign mux_rst    = int_rst || abort;

  channel_arbiter u_arbiter (
    .clk     (clk),
    .int_rst (int_rst),
    .clear   (abort),
    .arb     (arb)
  );

  stream_select_mux u_mux (
    .clk        (clk),
    .int_rst    (mux_rst),
    .enable     (mux_enable),
    .select     (arb.grant_index),
    .final_flag (final_flag),
    .ins        (ins),
    .out        (mux_out)
  );

  // Output stage marks tlast only on the final packet of the operation
  assign out.tdata      = mux_out.tdata;
  assign out.tkeep      = mux_out.tkeep;
  assign out.tvalid     = mux_out.tvalid;
  assign out.tlast      = mux_out.tlast && mux_out.final_tag;
  assign out.final_tag  = mux_out.final_tag;
  assign mux_out.tready = out.tready;

  assign out_fire  = mux_out.tvalid && out.tready;
  assign last_fire = out_fire && mux_out.tlast && mux_out.final_tag;

  always_ff @(posedge clk) begin
    if (int_rst || abort) begin
      state     <= op_idle;
      remaining <= '0;
    end else begin
      case (state)
        op_idle, op_done: begin
          if (start && (use_mask != '0)) begin
            state     <= op_run;
            remaining <= use_mask;
          end else if (start) begin
            state <= op_fault;
          end else begin
            state <= op_idle;
          end
        end
        op_run: begin
          remaining <= remaining & ~ack;
          if (last_fire) begin
            state <= op_done;
          end
        end
        default: begin
          state <= op_idle;
        end
      endcase
    end
  end

  // Status straight from the state
  assign busy     = (state == op_run);
  assign complete = (state == op_done);
  assign error    = (state == op_fault);

  always_ff @(posedge clk) begin
    if (int_rst) begin
      beat_sent <= 1'b0;
    end else begin
      beat_sent <= out_fire;
    end
  end

  a_status_excl: assert property (
    @(posedge clk) disable iff (int_rst)
    !(complete && error)
  );

endmodule

`default_nettype wire

// File: hdl/stream_select_mux.sv
`timescale 1ns/1ps
`default_nettype none

module stream_select_mux import join_cfg_pkg::*; (
  input logic                      clk,
  input logic                      int_rst,
  input logic                      enable,
  input logic [chan_idx_width-1:0] select,
  input logic                      final_flag,
  stream_if.sink                   ins [num_channels],
  stream_if.source                 out
);

  logic [data_width-1:0]   in_data [num_channels];
  logic [keep_width-1:0]   in_keep [num_channels];
  logic [num_channels-1:0] in_valid;
  logic [num_channels-1:0] in_last;

  logic                    slot_free;
  logic                    take;

  logic                    valid_q;
  logic [data_width-1:0]   data_q;
  logic [keep_width-1:0]   keep_q;
  logic                    last_q;
  logic                    tag_q;

  // Output register is empty or drains this cycle
  assign slot_free = !valid_q || out.tready;
  assign take      = enable && in_valid[select] && slot_free;

  for (genvar g = 0; g < num_channels; g++) begin : g_in
    assign in_data[g]  = ins[g].tdata;
    assign in_keep[g]  = ins[g].tkeep;
    assign in_valid[g] = ins[g].tvalid;
    assign in_last[g]  = ins[g].tlast;

    // Only the selected channel sees ready
    assign ins[g].tready = enable && (select == chan_idx_width'(g)) && slot_free;
  end

  always_ff @(posedge clk) begin
    if (int_rst) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (out.tready) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on an accepted input beat
  always_ff @(posedge clk) begin
    if (take) begin
      data_q <= in_data[select];
      keep_q <= in_keep[select];
      last_q <= in_last[select];
      tag_q  <= final_flag;
    end
  end

  assign out.tvalid    = valid_q;
  assign out.tdata     = data_q;
  assign out.tkeep     = keep_q;
  assign out.tlast     = last_q;
  assign out.final_tag = tag_q;

  // Stalled output beat must hold until accepted
  a_out_stable: assert property (
    @(posedge clk) disable iff (int_rst)
    (out.tvalid && !out.tready)
      |=> (out.tvalid && $stable(out.tdata) && $stable(out.tkeep)
           && $stable(out.tlast) && $stable(out.final_tag))
  );

endmodule

`default_nettype wire

// File: hdl/channel_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module channel_arbiter import join_cfg_pkg::*; (
  input logic   clk,
  input logic   int_rst,
  input logic   clear,
  arb_if.arbiter arb
);

  logic [num_channels-1:0]   grant_q;
  logic [chan_idx_width-1:0] index_q;
  logic [num_channels-1:0]   pending;
  logic [num_channels-1:0]   next_grant;
  logic                      grant_free;

  // Isolate the lowest set bit
  function automatic logic [num_channels-1:0] lowest_bit(
    input logic [num_channels-1:0] req
  );
    return req & (~req + 1'b1);
  endfunction

  function automatic logic [chan_idx_width-1:0] encode(
    input logic [num_channels-1:0] onehot
  );
    logic [chan_idx_width-1:0] idx;
    idx = '0;
    for (int i = 0; i < num_channels; i++) begin
      if (onehot[i]) begin
        idx = i[chan_idx_width-1:0];
      end
    end
    return idx;
  endfunction

  // An acknowledged channel drops out of the candidates right away,
  // so the next packet follows without a bubble
  assign pending    = arb.request & ~arb.acknowledge;
  assign next_grant = lowest_bit(pending);
  assign grant_free = (grant_q == '0) || ((arb.acknowledge & grant_q) != '0);

  always_ff @(posedge clk) begin
    if (int_rst || clear) begin
      grant_q <= '0;
      index_q <= '0;
    end else if (grant_free) begin
      grant_q <= next_grant;
      index_q <= encode(next_grant);
    end
  end

  assign arb.grant       = grant_q;
  assign arb.grant_valid = |grant_q;
  assign arb.grant_index = index_q;

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (int_rst)
    $onehot0(arb.grant)
  );

  // Granted packet is never interleaved with another channel
  a_grant_held: assert property (
    @(posedge clk) disable iff (int_rst)
    (arb.grant_valid && !clear && ((arb.acknowledge & arb.grant) == '0))
      |=> (arb.grant == $past(arb.grant))
  );

endmodule

`default_nettype wire

// File: hdl/stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Ready/valid beat stream with data and byte keep
interface stream_if import join_cfg_pkg::*; ();
  logic [data_width-1:0] tdata;
  logic [keep_width-1:0] tkeep;
  logic                  tvalid;
  logic                  tready;
  logic                  tlast;
  // Beat belongs to the last packet of the operation
  logic                  final_tag;

  modport source (
    output tdata, tkeep, tvalid, tlast, final_tag,
    input  tready
  );

  modport sink (
    input  tdata, tkeep, tvalid, tlast, final_tag,
    output tready
  );
endinterface

// Request/grant link between the joiner control and its arbiter
interface arb_if import join_cfg_pkg::*; ();
  logic [num_channels-1:0]   request;
  // One-hot marker of the last beat accepted from the granted channel
  logic [num_channels-1:0]   acknowledge;
  logic [num_channels-1:0]   grant;
  logic                      grant_valid;
  logic [chan_idx_width-1:0] grant_index;

  modport requester (
    output request, acknowledge,
    input  grant, grant_valid, grant_index
  );

  modport arbiter (
    input  request, acknowledge,
    output grant, grant_valid, grant_index
  );
endinterface

`default_nettype wire

// File: hdl/join_ctrl_pkg.sv
`default_nettype none

package join_ctrl_pkg;

  // Operation state of the joiner
  // idle  waits for a start command
  // run   moves packets from the selected channels
  // done  complete pulse in the cycle after the final beat left
  // fault error pulse in the cycle after a start with an empty mask
  typedef enum logic [1:0] {
    op_idle  = 2'd0,
    op_run   = 2'd1,
    op_done  = 2'd2,
    op_fault = 2'd3
  } op_state_t;

endpackage

`default_nettype wire

// File: hdl/join_cfg_pkg.sv
`default_nettype none

package join_cfg_pkg;

  // Number of input streams feeding the joiner
  localparam int num_channels = 4;

  // Beat payload
  localparam int data_width = 32;
  localparam int keep_width = data_width / 8;

  // Encoded channel number, wide enough for num_channels
  localparam int chan_idx_width = $clog2(num_channels);

endpackage

`default_nettype wire
